// ==== design/ula_defs.svh ====
`default_nettype none

`ifndef ULA_DEFS_SVH
`define ULA_DEFS_SVH

////////////////////////////////////////
// raster geometry
////////////////////////////////////////

// pixel clocks per line
`define H_TOTAL 448
// lines per frame
`define V_TOTAL 312
// paper area
`define PAPER_WIDTH 256
`define PAPER_HEIGHT 192
// fetch runs this far ahead of the beam
`define FETCH_OFFSET 8
// hc where paper pixel 0 reaches r/g/b
`define PIXEL_LATENCY 14
// frame interrupt
`define INT_LINE 248
`define INT_WIDTH 64

////////////////////////////////////////
// cpu ports
////////////////////////////////////////

// only sits in the decode chain ahead of ULAplus
`define TIMEX_PORT 8'hFF
`define ULAPLUS_ADDR 16'hBF3B
`define ULAPLUS_DATA 16'hFF3B

////////////////////////////////////////
// colour
////////////////////////////////////////

`define LEVEL_HALF 3'b101
`define LEVEL_FULL 3'b111
// red border out of reset
`define RESET_BORDER 3'b010
// frame counter bit that toggles flash, 16 frames per phase
`define FLASH_BIT 4

`endif

`default_nettype wire

// ==== design/ulaPkg.sv ====
`default_nettype none

package ulaPkg;

   // beam position
   typedef logic [8:0] hCount_t;
   typedef logic [8:0] vCount_t;

   // 16 KB video memory
   typedef logic [13:0] vramAddr_t;

   // bright, green, red, blue
   typedef logic [3:0] igrb_t;

   // GGGRRRBBB
   typedef logic [8:0] grb9_t;

   // ULAplus lut entry, two clut bits + paper/ink bit + colour
   typedef logic [5:0] palIndex_t;

endpackage

`default_nettype wire

// ==== design/rasterCounter.sv ====
`timescale 1ns/10ps
`include "ula_defs.svh"
`default_nettype none

module rasterCounter (
   input  wire             clk7,
   input  wire             rst_n,
   output ulaPkg::hCount_t hc,
   output ulaPkg::vCount_t vc,
   output logic            intN,
   output logic            flashPhase
);

   logic [4:0] flashCount;
   logic       lineEnd;
   logic       frameEnd;
   logic       intLine;

   // last pixel of line, last line of frame
   assign lineEnd  = (hc == ulaPkg::hCount_t'(`H_TOTAL - 1));
   assign frameEnd = (vc == ulaPkg::vCount_t'(`V_TOTAL - 1));
   assign intLine  = (vc == ulaPkg::vCount_t'(`INT_LINE));

   ////////////////////////////////////////
   // beam counters
   ////////////////////////////////////////

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         hc <= '0;
         vc <= '0;
      end else if (lineEnd) begin
         hc <= '0;
         // line advances on horizontal wrap
         vc <= frameEnd ? '0 : vc + 1'b1;
      end else begin
         hc <= hc + 1'b1;
      end
   end

   // one step per frame, at the start of the interrupt
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         flashCount <= '0;
      end else if (intLine && hc == '0) begin
         flashCount <= flashCount + 1'b1;
      end
   end

   assign flashPhase = flashCount[`FLASH_BIT];

   // 64 pixel clocks = 32 T-states low
   assign intN = !(intLine && hc < ulaPkg::hCount_t'(`INT_WIDTH));

   // line counter never runs past the last pixel
   hcRange: assert property (@(posedge clk7) disable iff (!rst_n)
      hc < ulaPkg::hCount_t'(`H_TOTAL));

endmodule

`default_nettype wire

// ==== design/fetchSequencer.sv ====
`timescale 1ns/10ps
`include "ula_defs.svh"
`default_nettype none

module fetchSequencer (
   input  wire               clk7,
   input  wire               rst_n,
   input  wire ulaPkg::hCount_t hc,
   input  wire ulaPkg::vCount_t vc,
   input  wire [7:0]         vramData,
   output ulaPkg::vramAddr_t va,
   output logic [7:0]        bitmapByte,
   output logic [7:0]        attrByte,
   output logic              serializerLoad,
   output logic              attrLoad,
   output logic              videoEnable
);

   // attributes follow the 6144 byte bitmap
   localparam ulaPkg::vramAddr_t AttrBase =
      ulaPkg::vramAddr_t'(`PAPER_WIDTH * `PAPER_HEIGHT / 8);

   logic [4:0] colAddr;
   logic       bitmapPhase;
   logic       attrPhase;
   logic       bitmapStrobe;
   logic       attrStrobe;

   ////////////////////////////////////////
   // fetch window and phases
   ////////////////////////////////////////

   // paper window shifted by the fetch lead
   assign videoEnable = (hc >= ulaPkg::hCount_t'(`FETCH_OFFSET))
      && (hc < ulaPkg::hCount_t'(`PAPER_WIDTH + `FETCH_OFFSET))
      && (vc < ulaPkg::vCount_t'(`PAPER_HEIGHT));

   // nibbles 8-9 and 12-13 bitmap, 10-11 and 14-15 attribute
   assign bitmapPhase = videoEnable && hc[3] && !hc[1];
   assign attrPhase   = videoEnable && hc[3] && hc[1];

   // latch on the second cycle of each phase
   assign bitmapStrobe = bitmapPhase && hc[0];
   assign attrStrobe   = attrPhase && hc[0];

   // every 8 clocks, serializer only inside the window
   assign attrLoad       = (hc[2:0] == 3'd4);
   assign serializerLoad = videoEnable && attrLoad;

   // column sampled one clock before each fetch pair
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         colAddr <= '0;
      end else if (hc[2:0] == 3'd3) begin
         colAddr <= hc[7:3];
      end
   end

   ////////////////////////////////////////
   // vram address
   ////////////////////////////////////////

   always_comb begin
      if (bitmapPhase) begin
         // y7 y6 y2 y1 y0 y5 y4 y3 interleave
         va = {1'b0, vc[7:6], vc[2:0], vc[5:3], colAddr};
      end else if (attrPhase) begin
         // one attribute per 8x8 cell
         va = AttrBase | {4'b0000, vc[7:3], colAddr};
      end else begin
         va = '0;
      end
   end

   // data latches
   always_ff @(posedge clk7) begin
      if (bitmapStrobe) begin
         bitmapByte <= vramData;
      end
      if (attrStrobe) begin
         attrByte <= vramData;
      end
   end

   // va carries one kind of address at a time
   phaseExclusive: assert property (@(posedge clk7) disable iff (!rst_n)
      !(bitmapPhase && attrPhase));

endmodule

`default_nettype wire

// ==== design/cpuPortDecoder.sv ====
`timescale 1ns/10ps
`include "ula_defs.svh"
`default_nettype none

module cpuPortDecoder (
   input  wire                clk7,
   input  wire                rst_n,
   input  wire [15:0]         a,
   input  wire                iorqN,
   input  wire                rdN,
   input  wire                wrN,
   input  wire [7:0]          din,
   input  wire                ear,
   input  wire [4:0]          kbd,
   input  wire [7:0]          cpuEntry,
   output logic [7:0]         dout,
   output logic [2:0]         border,
   output logic               ulaplusEnable,
   output logic               palWrite,
   output ulaPkg::palIndex_t  palWriteIndex,
   output logic [7:0]         palWriteData,
   output ulaPkg::palIndex_t  palReadIndex
);

   logic       ioWrite;
   logic       ioRead;
   logic       feSel;
   logic       addrSel;
   logic       dataSel;
   logic       configWrite;
   logic       configFlag;
   // bit 6 picks config group, 5:0 palette entry
   logic [6:0] regSelect;

   ////////////////////////////////////////
   // decode
   ////////////////////////////////////////

   assign ioWrite = !iorqN && !wrN;
   assign ioRead  = !iorqN && !rdN;

   // ula answers any even address
   assign feSel = !a[0];

   // odd ports, Timex port first in the priority chain
   assign addrSel = a[0] && (a[7:0] != `TIMEX_PORT) && (a == `ULAPLUS_ADDR);
   assign dataSel = a[0] && (a[7:0] != `TIMEX_PORT) && (a == `ULAPLUS_DATA);

   // data port goes to the lut or the config flag
   assign palWrite    = ioWrite && dataSel && !regSelect[6];
   assign configWrite = ioWrite && dataSel && regSelect[6];

   assign palWriteIndex = regSelect[5:0];
   assign palWriteData  = din;
   assign palReadIndex  = regSelect[5:0];
   assign ulaplusEnable = configFlag;

   ////////////////////////////////////////
   // registers
   ////////////////////////////////////////

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         border     <= `RESET_BORDER;
         regSelect  <= '0;
         configFlag <= 1'b0;
      end else begin
         if (ioWrite && feSel) begin
            border <= din[2:0];
         end
         if (ioWrite && addrSel) begin
            regSelect <= din[6:0];
         end
         // only mode bit 0 is implemented
         if (configWrite) begin
            configFlag <= din[0];
         end
      end
   end

   // read mux, idle bus reads high
   always_comb begin
      dout = 8'hFF;
      if (ioRead) begin
         if (feSel) begin
            dout = {1'b1, ear, 1'b1, kbd};
         end else if (addrSel) begin
            dout = {1'b0, regSelect};
         end else if (dataSel && !regSelect[6]) begin
            dout = cpuEntry;
         end else if (dataSel) begin
            dout = {7'b0000000, configFlag};
         end
      end
   end

   // one data write lands in exactly one place
   dataWriteTarget: assert property (@(posedge clk7) disable iff (!rst_n)
      !(palWrite && configWrite));

endmodule

`default_nettype wire

// ==== design/paletteLut.sv ====
`timescale 1ns/10ps
`default_nettype none

module paletteLut (
   input  wire                clk7,
   input  wire                palWrite,
   input  wire ulaPkg::palIndex_t palWriteIndex,
   input  wire [7:0]          palWriteData,
   input  wire ulaPkg::palIndex_t palReadIndex,
   input  wire ulaPkg::palIndex_t paperIndex,
   input  wire ulaPkg::palIndex_t inkIndex,
   output logic [7:0]         cpuEntry,
   output logic [7:0]         paperEntry,
   output logic [7:0]         inkEntry
);

   localparam int Entries = 2 ** $bits(ulaPkg::palIndex_t);

   // GGGRRRBB per entry
   logic [7:0] palMem [Entries];

   // all black at power up
   initial begin
      for (int i = 0; i < Entries; i++) begin
         palMem[i] = 8'h00;
      end
   end

   // cpu write port
   always_ff @(posedge clk7) begin
      if (palWrite) begin
         palMem[palWriteIndex] <= palWriteData;
      end
   end

   // three asynchronous read ports
   assign cpuEntry   = palMem[palReadIndex];
   assign paperEntry = palMem[paperIndex];
   assign inkEntry   = palMem[inkIndex];

endmodule

`default_nettype wire

// ==== design/pixelColourizer.sv ====
`timescale 1ns/10ps
`include "ula_defs.svh"
`default_nettype none

module pixelColourizer (
   input  wire                clk7,
   input  wire                rst_n,
   input  wire ulaPkg::hCount_t hc,
   input  wire [7:0]          bitmapByte,
   input  wire [7:0]          attrByte,
   input  wire                serializerLoad,
   input  wire                attrLoad,
   input  wire                videoEnable,
   input  wire                flashPhase,
   input  wire [2:0]          border,
   input  wire                ulaplusEnable,
   input  wire [7:0]          paperEntry,
   input  wire [7:0]          inkEntry,
   output ulaPkg::palIndex_t  paperIndex,
   output ulaPkg::palIndex_t  inkIndex,
   output logic [2:0]         r,
   output logic [2:0]         g,
   output logic [2:0]         b
);

   logic [7:0]    shiftReg;
   logic [7:0]    nextAttr;
   logic [7:0]    attrOut;
   logic [7:0]    plusPaper;
   logic [7:0]    plusInk;
   logic [7:0]    plusEntry;
   logic          pixel;
   logic          flashedPixel;
   ulaPkg::igrb_t stdIgrb;
   ulaPkg::grb9_t stdColour;
   ulaPkg::grb9_t plusColour;
   ulaPkg::grb9_t finalColour;

   // standard palette, bright selects full over half
   function automatic ulaPkg::grb9_t igrbToGrb9(input ulaPkg::igrb_t c);
      logic [2:0] level;
      level = c[3] ? `LEVEL_FULL : `LEVEL_HALF;
      return {c[2] ? level : 3'b000, c[1] ? level : 3'b000, c[0] ? level : 3'b000};
   endfunction

   ////////////////////////////////////////
   // serializer and attribute
   ////////////////////////////////////////

   // msb first, zeros fill in so the border stays paper
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         shiftReg <= '0;
      end else if (serializerLoad) begin
         shiftReg <= bitmapByte;
      end else begin
         shiftReg <= {shiftReg[6:0], 1'b0};
      end
   end

   assign pixel = shiftReg[7];

   // border as paper colour with no flash or bright
   assign nextAttr = videoEnable ? attrByte : {2'b00, border, 3'b000};

   // flash+bright pick the clut, then paper/ink half
   assign paperIndex = {nextAttr[7:6], 1'b1, nextAttr[5:3]};
   assign inkIndex   = {nextAttr[7:6], 1'b0, nextAttr[2:0]};

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         attrOut <= '0;
      end else if (attrLoad) begin
         attrOut <= nextAttr;
      end
   end

   // lut outputs held alongside the attribute
   always_ff @(posedge clk7) begin
      if (attrLoad) begin
         plusPaper <= paperEntry;
         plusInk   <= inkEntry;
      end
   end

   ////////////////////////////////////////
   // colour select
   ////////////////////////////////////////

   // flash inverts the pixel while the phase is high
   assign flashedPixel = pixel ^ (attrOut[7] & flashPhase);
   assign stdIgrb      = {attrOut[6], flashedPixel ? attrOut[2:0] : attrOut[5:3]};
   assign stdColour    = igrbToGrb9(stdIgrb);

   // ULAplus has no flash, attribute bits are clut select
   assign plusEntry  = pixel ? plusInk : plusPaper;
   // blue b1 b0 widened to b1 b0 b1
   assign plusColour = {plusEntry, plusEntry[1]};

   assign finalColour = ulaplusEnable ? plusColour : stdColour;

   // output register, one clock after the serializer
   always_ff @(posedge clk7) begin
      g <= finalColour[8:6];
      r <= finalColour[5:3];
      b <= finalColour[2:0];
   end

   // load lines up with the raster so pixel 0 lands on PIXEL_LATENCY
   loadAlign: assert property (@(posedge clk7) disable iff (!rst_n)
      attrLoad |-> (hc[2:0] == 3'((`PIXEL_LATENCY - 2) % 8)));

endmodule

`default_nettype wire

// ==== design/ulaVideo.sv ====
`timescale 1ns/10ps
`default_nettype none

module ulaVideo (
   input  wire               clk7,
   input  wire               rst_n,
   // z80 side
   input  wire [15:0]        a,
   input  wire               iorqN,
   input  wire               rdN,
   input  wire               wrN,
   input  wire [7:0]         din,
   output logic [7:0]        dout,
   output logic              intN,
   // video memory
   output ulaPkg::vramAddr_t va,
   input  wire [7:0]         vramData,
   // keyboard and tape
   input  wire               ear,
   input  wire [4:0]         kbd,
   // GRB out
   output logic [2:0]        r,
   output logic [2:0]        g,
   output logic [2:0]        b
);

   ulaPkg::hCount_t   hc;
   ulaPkg::vCount_t   vc;
   ulaPkg::palIndex_t palWriteIndex;
   ulaPkg::palIndex_t palReadIndex;
   ulaPkg::palIndex_t paperIndex;
   ulaPkg::palIndex_t inkIndex;
   logic              flashPhase;
   logic [7:0]        bitmapByte;
   logic [7:0]        attrByte;
   logic              serializerLoad;
   logic              attrLoad;
   logic              videoEnable;
   logic [2:0]        border;
   logic              ulaplusEnable;
   logic              palWrite;
   logic [7:0]        palWriteData;
   logic [7:0]        cpuEntry;
   logic [7:0]        paperEntry;
   logic [7:0]        inkEntry;

   ////////////////////////////////////////
   // raster and fetch
   ////////////////////////////////////////

   rasterCounter raster (
      .clk7       (clk7),
      .rst_n      (rst_n),
      .hc         (hc),
      .vc         (vc),
      .intN       (intN),
      .flashPhase (flashPhase)
   );

   fetchSequencer fetch (
      .clk7           (clk7),
      .rst_n          (rst_n),
      .hc             (hc),
      .vc             (vc),
      .vramData       (vramData),
      .va             (va),
      .bitmapByte     (bitmapByte),
      .attrByte       (attrByte),
      .serializerLoad (serializerLoad),
      .attrLoad       (attrLoad),
      .videoEnable    (videoEnable)
   );

   ////////////////////////////////////////
   // cpu ports and palette
   ////////////////////////////////////////

   cpuPortDecoder ports (
      .clk7          (clk7),
      .rst_n         (rst_n),
      .a             (a),
      .iorqN         (iorqN),
      .rdN           (rdN),
      .wrN           (wrN),
      .din           (din),
      .ear           (ear),
      .kbd           (kbd),
      .cpuEntry      (cpuEntry),
      .dout          (dout),
      .border        (border),
      .ulaplusEnable (ulaplusEnable),
      .palWrite      (palWrite),
      .palWriteIndex (palWriteIndex),
      .palWriteData  (palWriteData),
      .palReadIndex  (palReadIndex)
   );

   paletteLut palette (
      .clk7          (clk7),
      .palWrite      (palWrite),
      .palWriteIndex (palWriteIndex),
      .palWriteData  (palWriteData),
      .palReadIndex  (palReadIndex),
      .paperIndex    (paperIndex),
      .inkIndex      (inkIndex),
      .cpuEntry      (cpuEntry),
      .paperEntry    (paperEntry),
      .inkEntry      (inkEntry)
   );

   // pixel path
   pixelColourizer colourizer (
      .clk7           (clk7),
      .rst_n          (rst_n),
      .hc             (hc),
      .bitmapByte     (bitmapByte),
      .attrByte       (attrByte),
      .serializerLoad (serializerLoad),
      .attrLoad       (attrLoad),
      .videoEnable    (videoEnable),
      .flashPhase     (flashPhase),
      .border         (border),
      .ulaplusEnable  (ulaplusEnable),
      .paperEntry     (paperEntry),
      .inkEntry       (inkEntry),
      .paperIndex     (paperIndex),
      .inkIndex       (inkIndex),
      .r              (r),
      .g              (g),
      .b              (b)
   );

endmodule

`default_nettype wire

// ==== verification/ulaVideoTb.sv ====
`timescale 1ns/10ps
`include "ula_defs.svh"
`default_nettype none

module ulaVideoTb;

   localparam int FrameCycles = `H_TOTAL * `V_TOTAL;
   // any beam position comes round within one frame
   localparam int WaitLimit = FrameCycles + 16;
   localparam int IntStart = `INT_LINE * `H_TOTAL;

   logic              clk7;
   logic              rst_n;
   logic [15:0]       a;
   logic              iorqN;
   logic              rdN;
   logic              wrN;
   logic [7:0]        din;
   logic [7:0]        dout;
   logic              intN;
   ulaPkg::vramAddr_t va;
   logic [7:0]        vramData;
   logic              ear;
   logic [4:0]        kbd;
   logic [2:0]        r;
   logic [2:0]        g;
   logic [2:0]        b;

   // 16 KB video memory, answers va at once
   logic [7:0] vram [16384];
   // clocks since reset, matches hc/vc of the beam
   int         cycleCount;
   logic       runActive;
   int         checkCount;

   assign vramData = vram[va];

   ulaVideo UUT (
      .clk7     (clk7),
      .rst_n    (rst_n),
      .a        (a),
      .iorqN    (iorqN),
      .rdN      (rdN),
      .wrN      (wrN),
      .din      (din),
      .dout     (dout),
      .intN     (intN),
      .va       (va),
      .vramData (vramData),
      .ear      (ear),
      .kbd      (kbd),
      .r        (r),
      .g        (g),
      .b        (b)
   );

   initial begin
      clk7 = 1'b0;
      forever #10 clk7 = ~clk7;
   end

   always @(posedge clk7) begin
      runActive <= rst_n;
      if (!rst_n) begin
         cycleCount <= 0;
      end else begin
         cycleCount <= cycleCount + 1;
      end
   end

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////

   task automatic failRun(input string reason);
      $display("%s", reason);
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped");
   endtask

   task automatic checkValue(input string name, input int expected, input int actual);
      checkCount++;
      if (expected != actual) begin
         failRun($sformatf("[ERROR] %s expected %0h actual %0h", name, expected, actual));
      end
   endtask

   task automatic expectFields(input int got, input int need, input string name);
      if (got != need) begin
         failRun($sformatf("%s in the trace has %0d fields instead of %0d", name, got, need));
      end
   endtask

   // low for the first INT_WIDTH clocks of INT_LINE, every frame
   function automatic logic intLevel(input int cycle);
      int framePos;
      framePos = cycle % FrameCycles;
      return !(framePos >= IntStart && framePos < IntStart + `INT_WIDTH);
   endfunction

   // interrupt line watched on every clock
   always @(negedge clk7) begin
      if (runActive) begin
         checkValue("intN", intLevel(cycleCount), intN);
      end
   end

   ////////////////////////////////////////
   // bus and beam helpers
   ////////////////////////////////////////

   // io write held for one clock
   task automatic portWrite(input logic [15:0] port, input logic [7:0] data);
      a = port;
      din = data;
      iorqN = 1'b0;
      wrN = 1'b0;
      @(negedge clk7);
      iorqN = 1'b1;
      wrN = 1'b1;
   endtask

   // read data sampled a half clock into the next cycle
   task automatic portRead(input logic [15:0] port, input logic [7:0] expected,
                           input string name);
      a = port;
      iorqN = 1'b0;
      rdN = 1'b0;
      @(negedge clk7);
      checkValue(name, expected, dout);
      iorqN = 1'b1;
      rdN = 1'b1;
   endtask

   task automatic waitFrames(input int count, input string name);
      int waited;
      for (int f = 0; f < count; f++) begin
         waited = 0;
         do begin
            @(negedge clk7);
            waited++;
            if (waited > WaitLimit) begin
               failRun($sformatf("%s never saw the start of a frame", name));
            end
         end while (cycleCount % FrameCycles != 0);
      end
   endtask

   // paper pixel x of line y shows at hc = x + PIXEL_LATENCY
   task automatic checkPixel(input int line, input int column, input int expected,
                             input string name);
      int targetPos;
      int waited;
      targetPos = line * `H_TOTAL + column + `PIXEL_LATENCY;
      waited = 0;
      do begin
         @(negedge clk7);
         waited++;
         if (waited > WaitLimit) begin
            failRun($sformatf("%s never reached line %0d column %0d", name, line, column));
         end
      end while (cycleCount % FrameCycles != targetPos);
      checkValue(name, expected, {g, r, b});
   endtask

   ////////////////////////////////////////
   // trace player
   ////////////////////////////////////////

   initial begin
      int         fd;
      int         ch;
      int         fields;
      int         argA;
      int         argB;
      int         argC;
      int         recordCount;
      logic [7:0] kind;
      string      name;

      rst_n = 1'b0;
      a = 16'h0000;
      iorqN = 1'b1;
      rdN = 1'b1;
      wrN = 1'b1;
      din = 8'h00;
      ear = 1'b0;
      kbd = 5'h1F;
      recordCount = 0;
      for (int i = 0; i < 16384; i++) begin
         vram[i] = 8'h00;
      end

      repeat (10) @(negedge clk7);
      rst_n = 1'b1;

      fd = $fopen("verification/ula_trace.txt", "r");
      if (fd == 0) begin
         failRun("could not open verification/ula_trace.txt");
      end

      ch = $fgetc(fd);
      while (ch != -1) begin
         kind = ch[7:0];
         if (kind == "#") begin
            // comment runs to end of line
            while (ch != -1 && ch[7:0] != "\n") begin
               ch = $fgetc(fd);
            end
         end else if (kind != " " && kind != "\t" && kind != "\n" && kind != "\r") begin
            recordCount++;
            name = $sformatf("record %0d (%c)", recordCount, kind);
            case (kind)
               "M": begin
                  fields = $fscanf(fd, "%h %h", argA, argB);
                  expectFields(fields, 2, name);
                  vram[argA[13:0]] = argB[7:0];
               end
               "W": begin
                  fields = $fscanf(fd, "%h %h", argA, argB);
                  expectFields(fields, 2, name);
                  portWrite(argA[15:0], argB[7:0]);
               end
               "R": begin
                  fields = $fscanf(fd, "%h %h", argA, argB);
                  expectFields(fields, 2, name);
                  portRead(argA[15:0], argB[7:0], name);
               end
               "S": begin
                  fields = $fscanf(fd, "%h %h", argA, argB);
                  expectFields(fields, 2, name);
                  ear = argA[0];
                  kbd = argB[4:0];
               end
               "F": begin
                  fields = $fscanf(fd, "%d", argA);
                  expectFields(fields, 1, name);
                  waitFrames(argA, name);
               end
               "P": begin
                  fields = $fscanf(fd, "%d %d %h", argA, argB, argC);
                  expectFields(fields, 3, name);
                  checkPixel(argA, argB, argC, name);
               end
               default: begin
                  failRun($sformatf("%s is not a known trace record", name));
               end
            endcase
         end
         ch = $fgetc(fd);
      end
      $fclose(fd);

      if (checkCount > 0) begin
         $display("NO ERRORS");
         $finish;
      end else begin
         failRun("the trace ran no checks");
      end
   end

endmodule

`default_nettype wire

// ==== verification/ula_trace.txt ====
# one record per line, values hex, F count and P line/column decimal
#   M addr data | W port data | R port expected | S ear kbd | F frames | P line column grb9
# line 0 char 0, bright blue ink on yellow
M 0000 F0
M 1800 71
# line 9 char 5, magenta ink on green
M 0125 81
M 1825 23
# line 100 char 31, flashing white ink on cyan
M 0C9F 0F
M 199F AF
# keyboard and ear through port FE
S 1 15
R 00FE F5
S 0 0A
R 00FE AA
# standard palette in frame 0
P 0 0 007
P 0 3 007
P 0 4 1F8
P 0 7 1F8
P 0 8 000
P 9 40 02D
P 9 41 140
P 9 47 02D
P 100 248 145
P 100 252 16D
# red border out of reset, then cyan
P 250 0 028
W 00FE 05
P 300 10 145
# flash phase high from frame 16
F 16
P 100 248 16D
P 100 252 145
# ULAplus select drops bit 7
W BF3B 91
R BF3B 11
W FF3B E3
R FF3B E3
W BF3B 1E
W FF3B 5E
R FF3B 5E
W BF3B 27
W FF3B 07
W BF3B 2D
W FF3B 9A
W BF3B 09
W FF3B 4C
W 00FE 01
# enable through the config group
W BF3B 40
W FF3B 01
R FF3B 01
R BF3B 40
P 0 0 1C7
P 0 4 0BD
P 0 8 000
P 9 40 000
P 100 248 135
P 100 252 00F
P 250 0 098

// ==== sources.f ====
+incdir+design
design/ulaPkg.sv
design/rasterCounter.sv
design/fetchSequencer.sv
design/cpuPortDecoder.sv
design/paletteLut.sv
design/pixelColourizer.sv
design/ulaVideo.sv
verification/ulaVideoTb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ULA video testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module ulaVideoTb -f sources.f

simOutput=$(./obj_dir/VulaVideoTb 2>&1) || true
printf '%s\n' "$simOutput"

if printf '%s\n' "$simOutput" | grep -qx "NO ERRORS"; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
